// File: src/cp0_defines.svh
// Data and address widths, interrupt width, CP0 register numbers, PrId and Status reset value
`ifndef CP0_DEFINES_SVH
`define CP0_DEFINES_SVH

// Widths
`define CP0_DATA_W      32
`define CP0_ADDR_W      5
`define HARD_INT_W      6

// Register numbers, select 0 only
`define CP0_BADVADDR    5'd8
`define CP0_COUNT       5'd9
`define CP0_COMPARE     5'd11
`define CP0_STATUS      5'd12
`define CP0_CAUSE       5'd13
`define CP0_EPC         5'd14
`define CP0_PRID        5'd15

// Company 0x00, implementation 0x42, revision 0x20
`define CP0_PRID_VAL    32'h0000_4220

// BEV and ERL set
`define STATUS_RESET    32'h0040_0004

`endif

// File: src/cp0Pkg.sv
// Exception kind, ExcCode and level enums; exception request, register write and event structs
`default_nettype none
`include "cp0_defines.svh"

package cp0Pkg;

    typedef enum logic [3:0] {
        excIntr = 4'd0,
        excCpU  = 4'd1,
        excRI   = 4'd2,
        excOv   = 4'd3,
        excTrap = 4'd4,
        excSys  = 4'd5,
        excBp   = 4'd6,
        excAdE  = 4'd7,
        excEret = 4'd8
    } excKind_e;

    // Cause.ExcCode as defined by MIPS32
    typedef enum logic [4:0] {
        codeIntr = 5'd0,
        codeAdEL = 5'd4,
        codeAdES = 5'd5,
        codeSys  = 5'd8,
        codeBp   = 5'd9,
        codeRI   = 5'd10,
        codeCpU  = 5'd11,
        codeOv   = 5'd12,
        codeTr   = 5'd13
    } excCode_e;

    // Bit 1 is ERL, bit 0 is EXL
    typedef enum logic [1:0] {
        levelNormal   = 2'b00,
        levelExc      = 2'b01,
        levelError    = 2'b10,
        levelErrorExc = 2'b11
    } excLevel_e;

    typedef struct packed {
        logic                   valid;
        excKind_e               kind;
        logic                   inSlot;   // Faulting instruction sits in a delay slot
        logic                   isStore;
        logic [`CP0_DATA_W-1:0] pc;
        logic [`CP0_DATA_W-1:0] badAddr;
        logic [1:0]             cpNum;
        logic [1:0]             spare;
    } excReq_t;

    typedef struct packed {
        logic                   en;
        logic [`CP0_ADDR_W-1:0] addr;
        logic [`CP0_DATA_W-1:0] data;
    } regWrite_t;

    typedef struct packed {
        logic     capture;   // Save EPC and BD
        logic     fault;     // Real exception, ERET excluded
        excCode_e code;
        logic [1:0] spare;
    } excEvent_t;

endpackage

`default_nettype wire

// File: src/excControl.sv
// Exception-level FSM (EXL/ERL) and ExcCode encoder driving the register file event
`timescale 1ns/1ns
`default_nettype none
`include "cp0_defines.svh"

module excControl (
    input  wire                     clk,
    input  wire                     rst,
    input  wire cp0Pkg::excReq_t    excReq_i,
    input  wire cp0Pkg::regWrite_t  regWr_i,
    output logic                    exl_o,
    output logic                    erl_o,
    output cp0Pkg::excEvent_t       excEvent_o
);
    import cp0Pkg::*;

    localparam logic [`CP0_DATA_W-1:0] statusInit = `STATUS_RESET;

    excLevel_e levelQ;
    excLevel_e levelD;
    excCode_e  codeEnc;
    logic      isFault;
    logic      statusWr;

    assign isFault  = excReq_i.valid && (excReq_i.kind != excEret);
    assign statusWr = regWr_i.en && (regWr_i.addr == `CP0_STATUS);

    assign exl_o = levelQ[0];
    assign erl_o = levelQ[1];

    // ERL is only changed by a Status write
    always_comb begin
        levelD = levelQ;
        if (excReq_i.valid) begin
            if (excReq_i.kind == excEret)
                levelD = excLevel_e'({levelQ[1], 1'b0});
            else
                levelD = excLevel_e'({levelQ[1], 1'b1});
        end else if (statusWr) begin
            levelD = excLevel_e'(regWr_i.data[2:1]);   // ERL, EXL
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            levelQ <= excLevel_e'(statusInit[2:1]);
        else
            levelQ <= levelD;
    end

    always_comb begin
        case (excReq_i.kind)
            excIntr: codeEnc = codeIntr;
            excCpU:  codeEnc = codeCpU;
            excRI:   codeEnc = codeRI;
            excOv:   codeEnc = codeOv;
            excTrap: codeEnc = codeTr;
            excSys:  codeEnc = codeSys;
            excBp:   codeEnc = codeBp;
            excAdE:  codeEnc = excReq_i.isStore ? codeAdES : codeAdEL;
            default: codeEnc = codeIntr;   // ERET, not recorded
        endcase
    end

    // Nested exceptions keep the first EPC
    always_comb begin
        excEvent_o.capture = isFault && !exl_o;
        excEvent_o.fault   = isFault;
        excEvent_o.code    = codeEnc;
        excEvent_o.spare   = 2'b00;
    end

    levelKnown: assert property (
        @(posedge clk) disable iff (rst) !$isunknown(levelQ)
    ) else $error("exception level unknown");

    // A capture enters EXL, so the next exception is nested
    captureSetsExl: assert property (
        @(posedge clk) disable iff (rst)
        excEvent_o.capture |=> exl_o && !excEvent_o.capture
    ) else $error("capture not followed by EXL set or raised again with EXL set");

endmodule

`default_nettype wire

// File: src/cp0Timer.sv
// Count/Compare registers and latched timer interrupt
`timescale 1ns/1ns
`default_nettype none
`include "cp0_defines.svh"

module cp0Timer (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         excValid_i,
    input  wire cp0Pkg::regWrite_t      regWr_i,
    output logic [`CP0_DATA_W-1:0]      count_o,
    output logic [`CP0_DATA_W-1:0]      compare_o,
    output logic                        timerInt_o
);
    logic countWr;
    logic compareWr;
    logic match;

    // Exception in the same cycle drops the write
    assign countWr   = regWr_i.en && !excValid_i && (regWr_i.addr == `CP0_COUNT);
    assign compareWr = regWr_i.en && !excValid_i && (regWr_i.addr == `CP0_COMPARE);

    assign match = (compare_o != '0) && (count_o == compare_o);

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            count_o <= '0;
        else if (countWr)
            count_o <= regWr_i.data;
        else
            count_o <= count_o + 32'd1;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            compare_o <= '0;
        else if (compareWr)
            compare_o <= regWr_i.data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            timerInt_o <= 1'b0;
        end else if (compareWr) begin
            timerInt_o <= 1'b0;   // Acknowledge
        end else if (match) begin
            timerInt_o <= 1'b1;
        end
    end

    noIntWithZeroCompare: assert property (
        @(posedge clk) disable iff (rst) timerInt_o |-> compare_o != '0
    ) else $error("timer interrupt set with Compare zero");

endmodule

`default_nettype wire

// File: src/cp0RegFile.sv
// Status, Cause, EPC and BadVAddr registers, field write masks, read mux and user-mode flag
`timescale 1ns/1ns
`default_nettype none
`include "cp0_defines.svh"

module cp0RegFile (
    input  wire                         clk,
    input  wire                         rst,
    input  wire cp0Pkg::excReq_t        excReq_i,
    input  wire cp0Pkg::excEvent_t      excEvent_i,
    input  wire                         exl_i,
    input  wire                         erl_i,
    input  wire cp0Pkg::regWrite_t      regWr_i,
    input  wire [`HARD_INT_W-1:0]       hardInt_i,
    input  wire [`CP0_DATA_W-1:0]       count_i,
    input  wire [`CP0_DATA_W-1:0]       compare_i,
    input  wire [`CP0_ADDR_W-1:0]       rdAddr_i,
    output logic [`CP0_DATA_W-1:0]      rdData_o,
    output logic                        usermode_o,
    output logic [`CP0_DATA_W-1:0]      statusQ_o,
    output logic [`CP0_DATA_W-1:0]      causeQ_o,
    output logic [`CP0_DATA_W-1:0]      epcQ_o
);
    import cp0Pkg::*;

    localparam logic [`CP0_DATA_W-1:0] statusInit = `STATUS_RESET;

    logic                   cu0;
    logic                   bev;
    logic [7:0]             im;
    logic                   um;
    logic                   ie;
    logic                   bd;
    logic [1:0]             ce;
    logic                   iv;
    logic [`HARD_INT_W-1:0] ipHw;
    logic [1:0]             ipSw;
    excCode_e               excCode;
    logic [`CP0_DATA_W-1:0] epc;
    logic [`CP0_DATA_W-1:0] badVAddr;
    logic                   wrEn;

    assign wrEn = regWr_i.en && !excReq_i.valid;

    assign statusQ_o = {3'b0, cu0, 5'b0, bev, 6'b0, im, 3'b0, um, 1'b0, erl_i, exl_i, ie};
    assign causeQ_o  = {bd, 1'b0, ce, 4'b0, iv, 7'b0, ipHw, ipSw, 1'b0, excCode, 2'b0};
    assign epcQ_o    = epc;

    assign usermode_o = um & ~(exl_i | erl_i);

    // Writable Status fields: CU0, BEV, IM, UM, IE
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cu0 <= statusInit[28];
            bev <= statusInit[22];
            im  <= statusInit[15:8];
            um  <= statusInit[4];
            ie  <= statusInit[0];
        end else if (wrEn && (regWr_i.addr == `CP0_STATUS)) begin
            cu0 <= regWr_i.data[28];
            bev <= regWr_i.data[22];
            im  <= regWr_i.data[15:8];
            um  <= regWr_i.data[4];
            ie  <= regWr_i.data[0];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bd      <= 1'b0;
            ce      <= 2'b00;
            iv      <= 1'b0;
            ipHw    <= '0;
            ipSw    <= 2'b00;
            excCode <= codeIntr;
        end else begin
            ipHw <= hardInt_i;   // IP[7:2] sampled every edge
            if (excEvent_i.fault) begin
                excCode <= excEvent_i.code;
                if (excEvent_i.capture)
                    bd <= excReq_i.inSlot;
                if (excReq_i.kind == excCpU)
                    ce <= excReq_i.cpNum;
            end else if (wrEn && (regWr_i.addr == `CP0_CAUSE)) begin
                iv   <= regWr_i.data[23];
                ipSw <= regWr_i.data[9:8];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            epc      <= '0;
            badVAddr <= '0;
        end else if (excEvent_i.fault) begin
            if (excEvent_i.capture)
                epc <= excReq_i.inSlot ? excReq_i.pc - 32'd4 : excReq_i.pc;   // Branch address
            if (excReq_i.kind == excAdE)
                badVAddr <= excReq_i.badAddr;
        end else if (wrEn) begin
            case (regWr_i.addr)
                `CP0_EPC:      epc <= regWr_i.data;
                `CP0_BADVADDR: badVAddr <= regWr_i.data;
                default:       ;
            endcase
        end
    end

    always_comb begin
        case (rdAddr_i)
            `CP0_BADVADDR: rdData_o = badVAddr;
            `CP0_COUNT:    rdData_o = count_i;
            `CP0_COMPARE:  rdData_o = compare_i;
            `CP0_STATUS:   rdData_o = statusQ_o;
            `CP0_CAUSE:    rdData_o = causeQ_o;
            `CP0_EPC:      rdData_o = epc;
            `CP0_PRID:     rdData_o = `CP0_PRID_VAL;
            default:       rdData_o = '0;
        endcase
    end

    // Event from the FSM must match the request seen here
    faultNeedsRequest: assert property (
        @(posedge clk) disable iff (rst)
        excEvent_i.fault |-> excReq_i.valid && (excReq_i.kind != excEret)
    ) else $error("fault event without a valid exception request");

endmodule

`default_nettype wire

// File: src/cp0Top.sv
// CP0 top level connecting the exception FSM, timer and register file
`timescale 1ns/1ns
`default_nettype none
`include "cp0_defines.svh"

module cp0Top (
    input  wire                         clk,
    input  wire                         rst,
    input  wire cp0Pkg::excReq_t        excReq_i,
    input  wire cp0Pkg::regWrite_t      regWr_i,
    input  wire [`CP0_ADDR_W-1:0]       rdAddr_i,
    input  wire [`HARD_INT_W-1:0]       hardInt_i,
    output logic [`CP0_DATA_W-1:0]      rdData_o,
    output logic                        usermode_o,
    output logic                        timerInt_o,
    output logic [`CP0_DATA_W-1:0]      statusQ_o,
    output logic [`CP0_DATA_W-1:0]      causeQ_o,
    output logic [`CP0_DATA_W-1:0]      epcQ_o
);
    import cp0Pkg::*;

    excEvent_t              excEvent;
    logic                   exl;
    logic                   erl;
    logic [`CP0_DATA_W-1:0] count;
    logic [`CP0_DATA_W-1:0] compare;

    excControl excControl_i (
        .clk        (clk),
        .rst        (rst),
        .excReq_i   (excReq_i),
        .regWr_i    (regWr_i),
        .exl_o      (exl),
        .erl_o      (erl),
        .excEvent_o (excEvent)
    );

    cp0Timer cp0Timer_i (
        .clk        (clk),
        .rst        (rst),
        .excValid_i (excReq_i.valid),   // ERET also blocks writes
        .regWr_i    (regWr_i),
        .count_o    (count),
        .compare_o  (compare),
        .timerInt_o (timerInt_o)
    );

    cp0RegFile cp0RegFile_i (
        .clk        (clk),
        .rst        (rst),
        .excReq_i   (excReq_i),
        .excEvent_i (excEvent),
        .exl_i      (exl),
        .erl_i      (erl),
        .regWr_i    (regWr_i),
        .hardInt_i  (hardInt_i),
        .count_i    (count),
        .compare_i  (compare),
        .rdAddr_i   (rdAddr_i),
        .rdData_o   (rdData_o),
        .usermode_o (usermode_o),
        .statusQ_o  (statusQ_o),
        .causeQ_o   (causeQ_o),
        .epcQ_o     (epcQ_o)
    );

endmodule

`default_nettype wire

// File: tests/tbUtil.svh
// Galois LFSR random source, value compare task, check counters and per-test report
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

int unsigned checkCount = 0;
int unsigned errorCount = 0;
int unsigned testChecks0 = 0;
int unsigned testErrors0 = 0;
logic [31:0] lfsrState = 32'd98;

// Taps x^32 + x^22 + x^2 + x + 1, one step per bit taken
function automatic logic [31:0] randBits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
        val = {val[30:0], lfsrState[0]};
        if (lfsrState[0])
            lfsrState = (lfsrState >> 1) ^ 32'h8020_0003;
        else
            lfsrState = lfsrState >> 1;
    end
    return val;
endfunction

task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
        errorCount++;
        $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
endtask

task automatic startTest();
    testChecks0 = checkCount;
    testErrors0 = errorCount;
endtask

task automatic reportTest(input string name);
    $display("%s: %0d checks, %0d errors", name, checkCount - testChecks0,
             errorCount - testErrors0);
endtask

`endif

// File: tests/cp0Tb.sv
// Testbench for cp0Top: clock, reset, watchdog, reference model and five random tests
`timescale 1ns/1ns
`default_nettype none
`include "cp0_defines.svh"

module cp0Tb;
    import cp0Pkg::*;

    `include "tbUtil.svh"

    localparam int clkPeriod   = 8;
    localparam int writeCount  = 200;
    localparam int excCount    = 100;
    localparam int timerRounds = 20;
    localparam int timerWindow = 24;
    localparam int hwCount     = 50;
    localparam int runCycles   = 16 + 2 * (writeCount + excCount)
                                 + timerRounds * (timerWindow + 6) + hwCount;
    localparam logic [31:0] statusMask = 32'h1040_FF17;   // CU0 BEV IM UM ERL EXL IE
    localparam logic [31:0] causeMask  = 32'h0080_0300;   // IV and IP[1:0]

    logic                   clk = 1'b0;
    logic                   rst;
    excReq_t                excReq;
    regWrite_t              regWr;
    logic [`CP0_ADDR_W-1:0] rdAddr;
    logic [`HARD_INT_W-1:0] hardInt;
    logic [31:0]            rdData;
    logic                   usermode;
    logic                   timerInt;
    logic [31:0]            statusQ;
    logic [31:0]            causeQ;
    logic [31:0]            epcQ;

    // Model registers as they stand after the last edge
    logic [31:0]            mStatus;
    logic [31:0]            mCause;
    logic [31:0]            mEpc;
    logic [31:0]            mBadVAddr;
    logic [31:0]            mCount;
    logic [31:0]            mCompare;
    logic                   mInt;

    excReq_t                curReq;   // Inputs seen by the DUT at the coming edge
    regWrite_t              curWr;
    logic [`HARD_INT_W-1:0] curHi;
    logic [`HARD_INT_W-1:0] hiNext;
    excReq_t                noReq;
    regWrite_t              noWr;

    always #(clkPeriod / 2) clk = ~clk;

    cp0Top dut_i (
        .clk        (clk),
        .rst        (rst),
        .excReq_i   (excReq),
        .regWr_i    (regWr),
        .rdAddr_i   (rdAddr),
        .hardInt_i  (hardInt),
        .rdData_o   (rdData),
        .usermode_o (usermode),
        .timerInt_o (timerInt),
        .statusQ_o  (statusQ),
        .causeQ_o   (causeQ),
        .epcQ_o     (epcQ)
    );

    function automatic logic [4:0] codeOf(input excKind_e kind, input logic isStore);
        case (kind)
            excCpU:  return 5'd11;
            excRI:   return 5'd10;
            excOv:   return 5'd12;
            excTrap: return 5'd13;
            excSys:  return 5'd8;
            excBp:   return 5'd9;
            excAdE:  return isStore ? 5'd5 : 5'd4;   // AdES or AdEL
            default: return 5'd0;
        endcase
    endfunction

    function automatic logic [31:0] modelRead(input logic [`CP0_ADDR_W-1:0] addr);
        case (addr)
            `CP0_BADVADDR: return mBadVAddr;
            `CP0_COUNT:    return mCount;
            `CP0_COMPARE:  return mCompare;
            `CP0_STATUS:   return mStatus;
            `CP0_CAUSE:    return mCause;
            `CP0_EPC:      return mEpc;
            `CP0_PRID:     return `CP0_PRID_VAL;
            default:       return 32'd0;
        endcase
    endfunction

    // One rising edge of the reference model
    task automatic modelStep();
        logic fault;
        logic wrOk;
        logic compareWr;
        fault     = curReq.valid && (curReq.kind != excEret);
        wrOk      = curWr.en && !curReq.valid;
        compareWr = wrOk && (curWr.addr == `CP0_COMPARE);
        if (compareWr)
            mInt = 1'b0;
        else if ((mCompare != 32'd0) && (mCount == mCompare))
            mInt = 1'b1;
        mCount = (wrOk && (curWr.addr == `CP0_COUNT)) ? curWr.data : mCount + 32'd1;
        if (compareWr)
            mCompare = curWr.data;
        mCause[15:10] = curHi;
        if (fault) begin
            mCause[6:2] = codeOf(curReq.kind, curReq.isStore);
            if (!mStatus[1]) begin
                mEpc = curReq.inSlot ? curReq.pc - 32'd4 : curReq.pc;
                mCause[31] = curReq.inSlot;
            end
            if (curReq.kind == excAdE)
                mBadVAddr = curReq.badAddr;
            if (curReq.kind == excCpU)
                mCause[29:28] = curReq.cpNum;
            mStatus[1] = 1'b1;
        end else if (curReq.valid) begin
            mStatus[1] = 1'b0;   // ERET
        end else if (curWr.en) begin
            case (curWr.addr)
                `CP0_STATUS:   mStatus = (mStatus & ~statusMask) | (curWr.data & statusMask);
                `CP0_CAUSE:    mCause = (mCause & ~causeMask) | (curWr.data & causeMask);
                `CP0_EPC:      mEpc = curWr.data;
                `CP0_BADVADDR: mBadVAddr = curWr.data;
                default:       ;
            endcase
        end
    endtask

    // Drive at the edge, then compare at the falling edge
    task automatic tick(input excReq_t r, input regWrite_t w, input logic [4:0] ra);
        @(posedge clk);
        modelStep();
        excReq  <= r;
        regWr   <= w;
        rdAddr  <= ra;
        hardInt <= hiNext;
        curReq = r;
        curWr  = w;
        curHi  = hiNext;
        @(negedge clk);
        checkEq("statusQ_o", statusQ, mStatus);
        checkEq("causeQ_o", causeQ, mCause);
        checkEq("epcQ_o", epcQ, mEpc);
        checkEq("rdData_o", rdData, modelRead(ra));
        checkEq("usermode_o", 32'(usermode), 32'(mStatus[4] & ~(mStatus[1] | mStatus[2])));
        checkEq("timerInt_o", 32'(timerInt), 32'(mInt));
    endtask

    task automatic resetTest();
        startTest();
        @(negedge clk);
        checkEq("Count in reset", rdData, 32'd0);
        checkEq("timerInt_o in reset", 32'(timerInt), 32'd0);
        checkEq("usermode_o in reset", 32'(usermode), 32'd0);
        @(posedge clk);
        rst <= 1'b0;
        tick(noReq, noWr, `CP0_STATUS);
        checkEq("Status", rdData, `STATUS_RESET);
        tick(noReq, noWr, `CP0_CAUSE);
        checkEq("Cause", rdData, 32'd0);
        tick(noReq, noWr, `CP0_EPC);
        checkEq("EPC", rdData, 32'd0);
        tick(noReq, noWr, `CP0_BADVADDR);
        checkEq("BadVAddr", rdData, 32'd0);
        tick(noReq, noWr, `CP0_COMPARE);
        checkEq("Compare", rdData, 32'd0);
        tick(noReq, noWr, `CP0_PRID);
        checkEq("PrId", rdData, `CP0_PRID_VAL);
        tick(noReq, noWr, 5'd3);
        checkEq("unmapped read", rdData, 32'd0);
        reportTest("Test 1 reset values");
    endtask

    task automatic writeTest();
        regWrite_t w;
        startTest();
        for (int i = 0; i < writeCount; i++) begin
            w.en   = 1'b1;
            w.addr = randBits(1) != 0 ? 5'(32'd8 + randBits(3)) : 5'(randBits(5));
            w.data = randBits(32);
            tick(noReq, w, w.addr);
            tick(noReq, noWr, w.addr);   // Readback
        end
        reportTest("Test 2 write and readback");
    endtask

    task automatic excTest();
        excReq_t     r;
        regWrite_t   w;
        logic [31:0] sel;
        logic [31:0] epcBefore;
        logic        nested;
        startTest();
        for (int i = 0; i < excCount; i++) begin
            r = noReq;
            w = noWr;
            sel = randBits(3);
            if (sel == 0) begin
                r.valid = 1'b1;
                r.kind  = excEret;
            end else if (sel == 1) begin
                w.en   = 1'b1;
                w.addr = `CP0_STATUS;
                w.data = (randBits(32) & ~32'h4) | 32'h10;   // UM set, ERL clear
            end else begin
                r.valid   = 1'b1;
                r.kind    = excKind_e'(4'(randBits(3)));
                r.inSlot  = 1'(randBits(1));
                r.isStore = 1'(randBits(1));
                r.pc      = randBits(32) & ~32'h3;
                r.badAddr = randBits(32);
                r.cpNum   = 2'(randBits(2));
                if (randBits(2) == 0) begin
                    w.en   = 1'b1;   // Lost to the exception
                    w.addr = 5'(32'd8 + randBits(3));
                    w.data = randBits(32);
                end
            end
            epcBefore = mEpc;
            nested    = mStatus[1] && r.valid && (r.kind != excEret);
            tick(r, w, `CP0_CAUSE);
            tick(noReq, noWr, `CP0_BADVADDR);
            if (nested)
                checkEq("epcQ_o after nested exception", epcQ, epcBefore);
        end
        reportTest("Test 3 exceptions");
    endtask

    task automatic timerTest();
        regWrite_t w;
        startTest();
        for (int i = 0; i < timerRounds; i++) begin
            w.en   = 1'b1;
            w.addr = `CP0_COUNT;
            w.data = randBits(8);
            tick(noReq, w, `CP0_COUNT);
            repeat (randBits(2)) tick(noReq, noWr, `CP0_COUNT);
            w.addr = `CP0_COMPARE;
            w.data = randBits(3) == 0 ? 32'd0 : mCount + randBits(4) + 32'd2;
            tick(noReq, w, `CP0_COMPARE);
            for (int k = 0; k < timerWindow; k++) begin
                tick(noReq, noWr, `CP0_COUNT);
                if (mCompare == 32'd0)
                    checkEq("timerInt_o with Compare zero", 32'(timerInt), 32'd0);
            end
        end
        reportTest("Test 4 timer");
    endtask

    task automatic hwIntTest();
        regWrite_t              w;
        logic [`HARD_INT_W-1:0] hiPrev;
        startTest();
        for (int i = 0; i < hwCount; i++) begin
            w = noWr;
            if (randBits(2) == 0) begin
                w.en   = 1'b1;
                w.addr = `CP0_CAUSE;
                w.data = randBits(32);
            end
            hiPrev = curHi;
            hiNext = 6'(randBits(6));
            tick(noReq, w, `CP0_CAUSE);
            checkEq("Cause IP[7:2]", 32'(causeQ[15:10]), 32'(hiPrev));
            checkEq("Cause IP[1:0]", 32'(causeQ[9:8]), 32'(mCause[9:8]));
        end
        hiNext = '0;
        reportTest("Test 5 hardware interrupts");
    endtask

    initial begin
        rst     <= 1'b1;
        excReq  <= '0;
        regWr   <= '0;
        rdAddr  <= `CP0_COUNT;
        hardInt <= '0;
        noReq  = '0;
        noWr   = '0;
        curReq = '0;
        curWr  = '0;
        curHi  = '0;
        hiNext = '0;
        mStatus   = `STATUS_RESET;
        mCause    = '0;
        mEpc      = '0;
        mBadVAddr = '0;
        mCount    = '0;
        mCompare  = '0;
        mInt      = 1'b0;
        repeat (2) @(posedge clk);
        resetTest();
        writeTest();
        excTest();
        timerTest();
        hwIntTest();
        $display("Total: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial begin
        #((runCycles + 200) * clkPeriod);
        $display("Timeout: the tests did not finish within %0d cycles", runCycles + 200);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: cp0Lite.f
+incdir+src
+incdir+tests
src/cp0Pkg.sv
src/excControl.sv
src/cp0Timer.sv
src/cp0RegFile.sv
src/cp0Top.sv
tests/cp0Tb.sv

// File: run.sh
#!/bin/sh
# Build and run the cp0Lite testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module cp0Tb -f cp0Lite.f -o cp0Sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cp0Sim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
exit 0
